// ==== rtl/tomasulo_consts.svh ====
/*
  Core constants for the in-order issue core
  Depths, widths, opcode encodings and execution pipe latencies
*/
`ifndef TOMASULO_CONSTS_SVH
`define TOMASULO_CONSTS_SVH

// Architectural register file
`define REG_N       16
`define REG_W       4
`define WORD_W      32
`define IMM_W       16
`define OP_W        3

// Instruction FIFO, index width excludes the wrap bit
`define FIFO_DEPTH  16
`define FIFO_PTR_W  4

// Arithmetic class
`define OP_ADD      3'd0
`define OP_SUB      3'd1
`define OP_LDI      3'd2
// Logic class
`define OP_AND      3'd3
`define OP_OR       3'd4
`define OP_XOR      3'd5
// Multiply class
`define OP_MUL      3'd6

// Cycles from issue to the beat on the result bus
`define LAT_ARITH   2
`define LAT_LOGIC   1
`define LAT_MPY     3

// One more than the longest latency
`define SLOT_W      4

`endif

// ==== rtl/tomasulo_pkg.sv ====
/*
  Shared types of the issue core
  Instruction word, issued operation and result bus beat
*/
`include "tomasulo_consts.svh"

package tomasulo_pkg;

  // Instruction as it sits in the FIFO, 31 bits
  typedef struct packed {
    logic [`REG_W-1:0]  ra1;
    logic [`REG_W-1:0]  ra0;
    logic [`REG_W-1:0]  wa;
    logic [`OP_W-1:0]   op;
    logic [`IMM_W-1:0]  imm;
  } inst_t;

  // Operation handed to one execution pipe, 88 bits
  // Operands are already read from the register file
  typedef struct packed {
    logic               valid;
    logic [`OP_W-1:0]   op;
    logic [`REG_W-1:0]  wa;
    logic [`WORD_W-1:0] a;
    logic [`WORD_W-1:0] b;
    logic [`IMM_W-1:0]  imm;
  } issue_t;

  // One beat on the shared result bus, 37 bits
  // An idle beat is all zeros so that pipe outputs can be ORed
  typedef struct packed {
    logic               valid;
    logic [`REG_W-1:0]  wa;
    logic [`WORD_W-1:0] wdata;
  } result_t;

endpackage

// ==== rtl/inst_fifo.sv ====
/*
  Instruction FIFO
  Circular store with wrap-bit pointers, head presented combinationally,
  empty and full flags registered from the next-state pointers
*/
`timescale 1ns/1ps
`include "tomasulo_consts.svh"

module inst_fifo #(
  parameter type T = tomasulo_pkg::inst_t
) (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  T     din,
  input  logic head_pop,
  output T     head,
  output logic head_vld,
  output logic full
);

  // Top bit of each pointer is the wrap bit and the rest index the store
  logic [`FIFO_PTR_W:0]   wr_ptr_r;
  logic [`FIFO_PTR_W:0]   rd_ptr_r;
  logic [`FIFO_PTR_W:0]   wr_ptr_nxt;
  logic [`FIFO_PTR_W:0]   rd_ptr_nxt;
  logic                   empty_r;
  logic                   full_r;
  T                       mem [`FIFO_DEPTH];

  assign wr_ptr_nxt = push ? wr_ptr_r + 1'b1 : wr_ptr_r;
  assign rd_ptr_nxt = head_pop ? rd_ptr_r + 1'b1 : rd_ptr_r;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      empty_r  <= 1'b1;
      full_r   <= 1'b0;
    end
    else
    begin
      wr_ptr_r <= wr_ptr_nxt;
      rd_ptr_r <= rd_ptr_nxt;
      // Equal pointers mean empty
      empty_r  <= (rd_ptr_nxt == wr_ptr_nxt);
      // Same index on opposite laps means every entry is in use
      full_r   <= (rd_ptr_nxt[`FIFO_PTR_W] != wr_ptr_nxt[`FIFO_PTR_W]) &&
                  (rd_ptr_nxt[`FIFO_PTR_W-1:0] == wr_ptr_nxt[`FIFO_PTR_W-1:0]);
    end
  end

  // Write port of the circular store
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr_r[`FIFO_PTR_W-1:0]] <= din;
    end
  end

  assign head     = mem[rd_ptr_r[`FIFO_PTR_W-1:0]];
  assign head_vld = ~empty_r;
  assign full     = full_r;

endmodule

// ==== rtl/dispatcher.sv ====
/*
  In-order dispatcher
  Issues the FIFO head to its execution pipe once sources and destination
  are free and the result bus cycle at the pipe latency is unreserved
*/
`timescale 1ns/1ps
`include "tomasulo_consts.svh"

module dispatcher (
  input  logic                   clk,
  input  logic                   rst,
  input  tomasulo_pkg::inst_t    head,
  input  logic                   head_vld,
  output logic                   head_pop,
  input  logic [`WORD_W-1:0]     rdata0,
  input  logic [`WORD_W-1:0]     rdata1,
  output tomasulo_pkg::issue_t   arith_iss,
  output tomasulo_pkg::issue_t   logic_iss,
  output tomasulo_pkg::issue_t   mpy_iss,
  input  logic                   wb_clr,
  input  logic [`REG_W-1:0]      wb_wa
);

  // One busy bit per register, set at issue and cleared at write-back
  logic [`REG_N-1:0]     busy_r;
  logic [`REG_N-1:0]     busy_nxt;
  // Bit i set means the result bus is taken i cycles from now
  logic [`SLOT_W-1:0]    slot_r;
  logic [`SLOT_W-1:0]    slot_nxt;
  // One-hot of the head's latency, used to test the slot word
  logic [`SLOT_W-1:0]    lat_mask;
  logic                  is_arith;
  logic                  is_logic;
  logic                  is_mpy;
  logic                  uses_src;
  logic                  src_busy;
  logic                  dst_busy;
  logic                  slot_taken;
  logic                  issue;
  tomasulo_pkg::issue_t  iss;

  // Opcode class decode
  always_comb
  begin
    is_arith = (head.op <= `OP_LDI);
    is_logic = (head.op >= `OP_AND) && (head.op <= `OP_XOR);
    // Unused encodings above MUL go to the multiply pipe as well
    is_mpy   = (head.op >= `OP_MUL);
    // Load-immediate reads no register
    uses_src = (head.op != `OP_LDI);
  end

  always_comb
  begin
    lat_mask = '0;
    if (is_arith)
    begin
      lat_mask[`LAT_ARITH] = 1'b1;
    end
    if (is_logic)
    begin
      lat_mask[`LAT_LOGIC] = 1'b1;
    end
    if (is_mpy)
    begin
      lat_mask[`LAT_MPY] = 1'b1;
    end
  end

  // Hazard checks, any one of them holds the head in the FIFO
  assign src_busy   = uses_src & (busy_r[head.ra0] | busy_r[head.ra1]);
  assign dst_busy   = busy_r[head.wa];
  assign slot_taken = |(slot_r & lat_mask);
  assign issue      = head_vld & ~src_busy & ~dst_busy & ~slot_taken;
  assign head_pop   = issue;

  // Operands come straight from the asynchronous register file read
  always_comb
  begin
    iss       = '0;
    iss.valid = issue;
    iss.op    = head.op;
    iss.wa    = head.wa;
    iss.a     = rdata0;
    iss.b     = rdata1;
    iss.imm   = head.imm;

    arith_iss       = iss;
    arith_iss.valid = issue & is_arith;
    logic_iss       = iss;
    logic_iss.valid = issue & is_logic;
    mpy_iss         = iss;
    mpy_iss.valid   = issue & is_mpy;
  end

  always_comb
  begin
    busy_nxt = busy_r;
    if (wb_clr)
    begin
      busy_nxt[wb_wa] = 1'b0;
    end
    // A busy destination blocks issue, so this never meets the clear above
    if (issue)
    begin
      busy_nxt[head.wa] = 1'b1;
    end
  end

  // The word shifts down one slot per cycle, so a reservation made now
  // lands one position below the latency that was tested
  assign slot_nxt = (slot_r >> 1) | (issue ? (lat_mask >> 1) : '0);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_r <= '0;
      slot_r <= '0;
    end
    else
    begin
      busy_r <= busy_nxt;
      slot_r <= slot_nxt;
    end
  end

endmodule

// ==== rtl/exe_pipe.sv ====
/*
  Execution pipe
  Computes the operation in the issue cycle and delays it through a
  LATENCY-deep chain, so the bus beat appears exactly LATENCY cycles later
*/
`timescale 1ns/1ps
`include "tomasulo_consts.svh"

module exe_pipe #(
  parameter int LATENCY = 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  tomasulo_pkg::issue_t  iss,
  output tomasulo_pkg::result_t res
);

  logic [`WORD_W-1:0]     result;
  tomasulo_pkg::result_t  beat;
  // Stage i holds the beat issued i+1 cycles ago
  tomasulo_pkg::result_t  stage_r [LATENCY];

  always_comb
  begin
    case (iss.op)
      `OP_ADD: result = iss.a + iss.b;
      `OP_SUB: result = iss.a - iss.b;
      // Immediate is zero-extended
      `OP_LDI: result = {{(`WORD_W-`IMM_W){1'b0}}, iss.imm};
      `OP_AND: result = iss.a & iss.b;
      `OP_OR:  result = iss.a | iss.b;
      `OP_XOR: result = iss.a ^ iss.b;
      // Low word of the product
      `OP_MUL: result = iss.a * iss.b;
      default: result = '0;
    endcase
  end

  // Idle beats are forced to zero since the top level ORs all pipes
  always_comb
  begin
    beat = '0;
    if (iss.valid)
    begin
      beat.valid = 1'b1;
      beat.wa    = iss.wa;
      beat.wdata = result;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < LATENCY; i++)
      begin
        stage_r[i] <= '0;
      end
    end
    else
    begin
      stage_r[0] <= beat;
      // Several operations can be in flight at once
      for (int i = 1; i < LATENCY; i++)
      begin
        stage_r[i] <= stage_r[i-1];
      end
    end
  end

  assign res = stage_r[LATENCY-1];

endmodule

// ==== rtl/reg_file.sv ====
/*
  Register file and write-back port
  Two asynchronous read ports, one write from the result bus, and the
  registered output beat that also clears the dispatcher busy bit
*/
`timescale 1ns/1ps
`include "tomasulo_consts.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`REG_W-1:0]     ra0,
  input  logic [`REG_W-1:0]     ra1,
  output logic [`WORD_W-1:0]    rdata0,
  output logic [`WORD_W-1:0]    rdata1,
  input  tomasulo_pkg::result_t bus,
  output logic                  wb_clr,
  output logic [`REG_W-1:0]     wb_wa,
  output logic                  out_vld_r,
  output logic [`REG_W-1:0]     out_wa_r,
  output logic [`WORD_W-1:0]    out_wdata_r
);

  // Architectural state starts at zero
  logic [`WORD_W-1:0] regs [`REG_N];

  assign rdata0 = regs[ra0];
  assign rdata1 = regs[ra1];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      regs <= '{default: '0};
    end
    else if (bus.valid)
    begin
      regs[bus.wa] <= bus.wdata;
    end
  end

  // Output beat follows the bus by one cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      out_vld_r   <= 1'b0;
      out_wa_r    <= '0;
      out_wdata_r <= '0;
    end
    else
    begin
      out_vld_r   <= bus.valid;
      out_wa_r    <= bus.wa;
      out_wdata_r <= bus.wdata;
    end
  end

  // The word is in the array by now, so readers may be released
  assign wb_clr = out_vld_r;
  assign wb_wa  = out_wa_r;

endmodule

// ==== rtl/tomasulo_top.sv ====
/*
  Issue core top level
  FIFO, dispatcher, arithmetic, logic and multiply pipes, shared result
  bus and register file with its write-back output
*/
`timescale 1ns/1ps
`include "tomasulo_consts.svh"

module tomasulo_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_pass,
  input  tomasulo_pkg::inst_t in_inst,
  output logic                in_accept,
  output logic                out_vld_r,
  output logic [`REG_W-1:0]   out_wa_r,
  output logic [`WORD_W-1:0]  out_wdata_r
);

  tomasulo_pkg::inst_t    head;
  logic                   head_vld;
  logic                   head_pop;
  logic                   fifo_push;
  logic                   fifo_full;
  logic [`WORD_W-1:0]     rdata0;
  logic [`WORD_W-1:0]     rdata1;
  tomasulo_pkg::issue_t   arith_iss;
  tomasulo_pkg::issue_t   logic_iss;
  tomasulo_pkg::issue_t   mpy_iss;
  tomasulo_pkg::result_t  arith_res;
  tomasulo_pkg::result_t  logic_res;
  tomasulo_pkg::result_t  mpy_res;
  tomasulo_pkg::result_t  bus;
  logic                   wb_clr;
  logic [`REG_W-1:0]      wb_wa;

  // Accept whenever the registered full flag is low
  assign in_accept = ~fifo_full;
  assign fifo_push = in_pass & in_accept;

  inst_fifo #(.T(tomasulo_pkg::inst_t)) u_fifo (
    .clk      (clk),
    .rst      (rst),
    .push     (fifo_push),
    .din      (in_inst),
    .head_pop (head_pop),
    .head     (head),
    .head_vld (head_vld),
    .full     (fifo_full)
  );

  dispatcher u_dispatcher (
    .clk       (clk),
    .rst       (rst),
    .head      (head),
    .head_vld  (head_vld),
    .head_pop  (head_pop),
    .rdata0    (rdata0),
    .rdata1    (rdata1),
    .arith_iss (arith_iss),
    .logic_iss (logic_iss),
    .mpy_iss   (mpy_iss),
    .wb_clr    (wb_clr),
    .wb_wa     (wb_wa)
  );

  exe_pipe #(.LATENCY(`LAT_ARITH)) u_arith (
    .clk (clk),
    .rst (rst),
    .iss (arith_iss),
    .res (arith_res)
  );

  exe_pipe #(.LATENCY(`LAT_LOGIC)) u_logic (
    .clk (clk),
    .rst (rst),
    .iss (logic_iss),
    .res (logic_res)
  );

  exe_pipe #(.LATENCY(`LAT_MPY)) u_mpy (
    .clk (clk),
    .rst (rst),
    .iss (mpy_iss),
    .res (mpy_res)
  );

  // Slot reservation keeps the three beats exclusive and idle pipes drive zero
  assign bus = tomasulo_pkg::result_t'(arith_res | logic_res | mpy_res);

  reg_file u_reg_file (
    .clk         (clk),
    .rst         (rst),
    .ra0         (head.ra0),
    .ra1         (head.ra1),
    .rdata0      (rdata0),
    .rdata1      (rdata1),
    .bus         (bus),
    .wb_clr      (wb_clr),
    .wb_wa       (wb_wa),
    .out_vld_r   (out_vld_r),
    .out_wa_r    (out_wa_r),
    .out_wdata_r (out_wdata_r)
  );

endmodule

// ==== bench/tomasulo_assertions.sv ====
/*
  Bound checks for the issue core
  Result bus exclusivity, FIFO overflow and output state during reset
*/
`timescale 1ns/1ps
`include "tomasulo_consts.svh"

module tomasulo_assertions (
  input logic clk,
  input logic rst,
  input logic arith_vld,
  input logic logic_vld,
  input logic mpy_vld,
  input logic fifo_push,
  input logic head_pop,
  input logic out_vld_r
);

  // Number of failed properties so far
  int fail_cnt = 0;
  // Entries held in the FIFO, counted from the push and pop strobes
  int occupancy;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      occupancy <= 0;
    end
    else
    begin
      occupancy <= occupancy + int'(fifo_push) - int'(head_pop);
    end
  end

  // Slot reservation must keep the three pipes off the bus in the same cycle
  a_one_beat: assert property (@(posedge clk) disable iff (rst)
    $onehot0({arith_vld, logic_vld, mpy_vld}))
  else
  begin
    fail_cnt++;
    $error("more than one pipe result on the shared bus");
  end

  // The producer may only push while the FIFO has room
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    (occupancy == `FIFO_DEPTH) |-> !fifo_push)
  else
  begin
    fail_cnt++;
    $error("instruction pushed into a full FIFO");
  end

  // Every reset edge leaves the output port idle
  a_out_reset: assert property (@(posedge clk) rst |=> !out_vld_r)
  else
  begin
    fail_cnt++;
    $error("output beat valid while in reset");
  end

endmodule

bind tomasulo_top tomasulo_assertions u_assertions (
  .clk       (clk),
  .rst       (rst),
  .arith_vld (arith_res.valid),
  .logic_vld (logic_res.valid),
  .mpy_vld   (mpy_res.valid),
  .fifo_push (fifo_push),
  .head_pop  (head_pop),
  .out_vld_r (out_vld_r)
);

// ==== bench/tb_tomasulo.sv ====
/*
  Testbench for the issue core
  Directed tests with a program-order register model, an expected beat
  queue matched per destination register, and a cycle watchdog
*/
`timescale 1ns/1ps
`include "tomasulo_consts.svh"

module tb_tomasulo;

  // One expected write-back beat
  typedef struct packed {
    logic [`REG_W-1:0]  wa;
    logic [`WORD_W-1:0] data;
  } exp_t;

  logic                clk = 1'b0;
  logic                rst;
  logic                in_pass;
  tomasulo_pkg::inst_t in_inst;
  logic                in_accept;
  logic                out_vld_r;
  logic [`REG_W-1:0]   out_wa_r;
  logic [`WORD_W-1:0]  out_wdata_r;

  // Register values as they stand after every instruction sent so far
  logic [`WORD_W-1:0]  model_regs [`REG_N];
  exp_t                exp_q [$];
  logic [31:0]         lfsr_state = 32'hebf143b2;
  int                  errors = 0;
  int                  checks = 0;
  int                  sent = 0;
  int                  cycles = 0;

  tomasulo_top UUT (
    .clk         (clk),
    .rst         (rst),
    .in_pass     (in_pass),
    .in_inst     (in_inst),
    .in_accept   (in_accept),
    .out_vld_r   (out_vld_r),
    .out_wa_r    (out_wa_r),
    .out_wdata_r (out_wdata_r)
  );

  always #4 clk = ~clk;

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // Result of one instruction as the opcode table defines it
  function automatic logic [`WORD_W-1:0] expected_result(input logic [`OP_W-1:0] op,
      input logic [`WORD_W-1:0] a, input logic [`WORD_W-1:0] b,
      input logic [`IMM_W-1:0] imm);
    case (op)
      `OP_ADD: return a + b;
      `OP_SUB: return a - b;
      `OP_LDI: return {16'h0000, imm};
      `OP_AND: return a & b;
      `OP_OR:  return a | b;
      `OP_XOR: return a ^ b;
      `OP_MUL: return a * b;
      default: return '0;
    endcase
  endfunction

  function automatic tomasulo_pkg::inst_t make_inst(input logic [`OP_W-1:0] op,
      input logic [`REG_W-1:0] wa, input logic [`REG_W-1:0] ra0,
      input logic [`REG_W-1:0] ra1, input logic [`IMM_W-1:0] imm);
    tomasulo_pkg::inst_t inst;
    inst.op  = op;
    inst.wa  = wa;
    inst.ra0 = ra0;
    inst.ra1 = ra1;
    inst.imm = imm;
    return inst;
  endfunction

  task automatic check_value(input string name, input logic [`WORD_W-1:0] got,
      input logic [`WORD_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Updates the model, queues the expected beat and holds the input until accepted
  task automatic push_inst(input tomasulo_pkg::inst_t inst);
    logic [`WORD_W-1:0] res;
    exp_t               e;
    res = expected_result(inst.op, model_regs[inst.ra0], model_regs[inst.ra1], inst.imm);
    model_regs[inst.wa] = res;
    e.wa   = inst.wa;
    e.data = res;
    exp_q.push_back(e);
    sent++;
    in_pass = 1'b1;
    in_inst = inst;
    while (!in_accept)
    begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  // Stops sending and waits until every queued beat has been seen
  task automatic drain();
    in_pass = 1'b0;
    while (exp_q.size() != 0)
    begin
      @(negedge clk);
    end
    // A few quiet cycles so that a stray extra beat is still caught
    repeat (4) @(negedge clk);
  endtask

  // Each beat takes the oldest pending entry for its register because writes
  // to one register stay in order
  task automatic match_output();
    int idx;
    idx = -1;
    for (int i = 0; i < exp_q.size(); i++)
    begin
      if (idx < 0 && exp_q[i].wa == out_wa_r)
      begin
        idx = i;
      end
    end
    if (idx < 0)
    begin
      errors++;
      $display("Output beat for register %0d at %0t has no pending instruction",
               out_wa_r, $time);
    end
    else
    begin
      check_value("out_wdata_r", out_wdata_r, exp_q[idx].data);
      exp_q.delete(idx);
    end
  endtask

  always @(negedge clk)
  begin
    if (out_vld_r === 1'b1)
    begin
      match_output();
    end
  end

  // Limit grows with the number of instructions sent
  always @(negedge clk)
  begin
    cycles++;
    if (cycles > 40 * sent + 200)
    begin
      $display("Timeout after %0d cycles with %0d results still pending",
               cycles, exp_q.size());
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic load_all_regs();
    logic [31:0] v;
    for (int r = 0; r < `REG_N; r++)
    begin
      rand_bits(16, v);
      // Odd registers get the top bit set to show the zero extension
      if (r[0])
      begin
        v[15] = 1'b1;
      end
      push_inst(make_inst(`OP_LDI, 4'(r), 4'd0, 4'd0, v[15:0]));
    end
    drain();
  endtask

  task automatic alu_op_chains();
    logic [31:0] v;
    logic [31:0] k;
    logic [31:0] wa;
    logic [31:0] ra0;
    logic [31:0] ra1;
    for (int r = 1; r <= 6; r++)
    begin
      rand_bits(16, v);
      push_inst(make_inst(`OP_LDI, 4'(r), 4'd0, 4'd0, v[15:0]));
    end
    // Each result feeds the next instruction
    push_inst(make_inst(`OP_ADD, 4'd7, 4'd1, 4'd2, 16'h0));
    push_inst(make_inst(`OP_SUB, 4'd8, 4'd7, 4'd3, 16'h0));
    push_inst(make_inst(`OP_AND, 4'd9, 4'd8, 4'd4, 16'h0));
    push_inst(make_inst(`OP_OR, 4'd10, 4'd9, 4'd5, 16'h0));
    push_inst(make_inst(`OP_XOR, 4'd11, 4'd10, 4'd7, 16'h0));
    for (int n = 0; n < 20; n++)
    begin
      rand_bits(3, k);
      rand_bits(4, wa);
      rand_bits(4, ra0);
      rand_bits(4, ra1);
      k = k % 5;
      // Skip the load-immediate encoding between SUB and AND
      k = (k < 2) ? k : k + 1;
      push_inst(make_inst(k[2:0], wa[3:0], ra0[3:0], ra1[3:0], 16'h0));
    end
    drain();
  endtask

  task automatic mul_logic_mix();
    logic [31:0] v;
    for (int round = 0; round < 3; round++)
    begin
      for (int r = 1; r <= 4; r++)
      begin
        rand_bits(16, v);
        push_inst(make_inst(`OP_LDI, 4'(r), 4'd0, 4'd0, v[15:0]));
      end
      // Logic results overtake the multiplies issued just before them
      push_inst(make_inst(`OP_MUL, 4'd12, 4'd1, 4'd2, 16'h0));
      push_inst(make_inst(`OP_OR, 4'd13, 4'd3, 4'd4, 16'h0));
      push_inst(make_inst(`OP_AND, 4'd14, 4'd5, 4'd6, 16'h0));
      push_inst(make_inst(`OP_MUL, 4'd15, 4'd7, 4'd8, 16'h0));
      push_inst(make_inst(`OP_XOR, 4'd0, 4'd9, 4'd10, 16'h0));
      push_inst(make_inst(`OP_OR, 4'd11, 4'd1, 4'd9, 16'h0));
    end
    drain();
  endtask

  task automatic same_dest_order();
    push_inst(make_inst(`OP_MUL, 4'd5, 4'd1, 4'd2, 16'h0));
    push_inst(make_inst(`OP_XOR, 4'd5, 4'd3, 4'd4, 16'h0));
    push_inst(make_inst(`OP_MUL, 4'd6, 4'd6, 4'd3, 16'h0));
    push_inst(make_inst(`OP_AND, 4'd6, 4'd1, 4'd7, 16'h0));
    push_inst(make_inst(`OP_MUL, 4'd9, 4'd2, 4'd8, 16'h0));
    push_inst(make_inst(`OP_OR, 4'd9, 4'd9, 4'd4, 16'h0));
    drain();
  endtask

  task automatic full_fifo_burst();
    int first_drop;
    first_drop = -1;
    for (int i = 0; i < 24; i++)
    begin
      if (!in_accept && first_drop < 0)
      begin
        first_drop = i;
      end
      // Every entry depends on the one before so the head stalls each time
      if (i[0])
      begin
        push_inst(make_inst(`OP_ADD, 4'd1, 4'd1, 4'd2, 16'h0));
      end
      else
      begin
        push_inst(make_inst(`OP_MUL, 4'd1, 4'd1, 4'd3, 16'h0));
      end
    end
    check_value("in_accept", (first_drop >= 16) ? 32'd1 : 32'd0, 32'd1);
    drain();
  endtask

  initial
  begin
    rst     = 1'b1;
    in_pass = 1'b0;
    in_inst = '0;
    for (int r = 0; r < `REG_N; r++)
    begin
      model_regs[r] = '0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    load_all_regs();
    alu_op_chains();
    mul_logic_mix();
    same_dest_order();
    full_fifo_burst();

    $display("Instructions: %0d  checks: %0d  errors: %0d  assertion failures: %0d",
             sent, checks, errors, UUT.u_assertions.fail_cnt);
    if (errors == 0 && UUT.u_assertions.fail_cnt == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/tomasulo_pkg.sv
rtl/inst_fifo.sv
rtl/dispatcher.sv
rtl/exe_pipe.sv
rtl/reg_file.sv
rtl/tomasulo_top.sv
bench/tomasulo_assertions.sv
bench/tb_tomasulo.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module tb_tomasulo \
  -f src.f -o tb_tomasulo_sim
./obj_dir/tb_tomasulo_sim +verilator+error+limit+100 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
exit 0
